// ==== dv/dirty_stimulus.txt ====
# op index value expect, all numbers in hex
# value is fill_dirty or the random burst length, expect ff means taken from the model only
queryall 00 00 00
mark 05 00 00
query 05 00 01
query 0d 00 00
markquery 0a 00 01
fill 11 01 00
query 11 00 01
fill 11 00 00
query 11 00 00
markfill 13 00 00
query 13 00 00
markfill 14 01 00
query 14 00 01
markclean 05 00 00
query 05 00 00
mark 3f 00 00
mark 20 00 00
clean 0a 00 00
queryall 00 00 03
flush 00 00 03
queryall 00 00 00
mark 02 00 00
mark 30 00 00
busyflush 04 00 02
query 04 00 00
mark 07 00 00
init 00 00 00
queryall 00 00 00
random 00 c8 ff
queryall 00 00 ff
flush 00 00 ff
queryall 00 00 00
idle 04 00 00

// ==== dcache_dirty_unit.f ====
rtl/dcache_dirty_pkg.sv
rtl/dirty_write_if.sv
rtl/dirty_bit_ram.sv
rtl/dirty_tracker.sv
rtl/flush_scanner.sv
rtl/dcache_dirty_unit.sv
dv/dcache_dirty_unit_tb.sv

// ==== Makefile ====
TOP := dcache_dirty_unit_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module dcache_dirty_unit -f dcache_dirty_unit.f

sim:
	verilator --binary --timing --top-module $(TOP) -f dcache_dirty_unit.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "^TEST PASSED$$"

clean:
	rm -rf obj_dir

// ==== dv/dcache_dirty_unit_tb.sv ====
//////////////////////////////////////////////////
// Testbench for the data cache dirty-line tracker
// File-driven commands checked against a line model
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module dcache_dirty_unit_tb import dcache_dirty_pkg::*; ();

  logic        clk;
  logic        rst;
  logic        mark_valid;
  line_index_t mark_index;
  logic        fill_valid;
  line_index_t fill_index;
  logic        fill_dirty;
  logic        clean_valid;
  line_index_t clean_index;
  logic        query_valid;
  line_index_t query_index;
  logic        init;
  logic        flush_start;
  logic        dirty_valid;
  logic        dirty;
  logic        wb_valid;
  line_index_t wb_index;
  logic        flush_done;
  logic        busy;

  logic        model [NUM_LINES];                     // Expected dirty bit of every line
  int          budget = 0;

  dcache_dirty_unit dcache_dirty_unit_inst (.*);

  initial clk = 1'b0;
  always #2 clk = ~clk;

  task automatic abort_run();
    $display("TEST FAILED");
    $fatal(1, "Stopped at the first failure");
  endtask

  task automatic check_dirty(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_index(input string name, input line_index_t got, input line_index_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic set_inputs(input logic mv, input line_index_t mi, input logic fv,
                            input line_index_t fi, input logic fd, input logic cv,
                            input line_index_t ci, input logic qv, input line_index_t qi);
    mark_valid  <= mv;
    mark_index  <= mi;
    fill_valid  <= fv;
    fill_index  <= fi;
    fill_dirty  <= fd;
    clean_valid <= cv;
    clean_index <= ci;
    query_valid <= qv;
    query_index <= qi;
    init        <= 1'b0;
    flush_start <= 1'b0;
  endtask

  task automatic drive_cmd(input logic mv, input line_index_t mi, input logic fv,
                           input line_index_t fi, input logic fd, input logic cv,
                           input line_index_t ci, input logic qv, input line_index_t qi);
    @(posedge clk);
    set_inputs(mv, mi, fv, fi, fd, cv, ci, qv, qi);
  endtask

  task automatic drive_idle();
    drive_cmd(1'b0, '0, 1'b0, '0, 1'b0, 1'b0, '0, 1'b0, '0);
  endtask

  // A fill takes port 0 away from a mark, and a clean is written last
  task automatic apply_model(input logic mv, input line_index_t mi, input logic fv,
                             input line_index_t fi, input logic fd, input logic cv,
                             input line_index_t ci);
    if (fv) model[fi] = fd;
    else if (mv) model[mi] = 1'b1;
    if (cv) model[ci] = 1'b0;
  endtask

  // One command cycle on a single line with the query answer due one cycle later
  task automatic run_op(input logic mv, input logic fv, input logic fd, input logic cv,
                        input logic qv, input line_index_t idx, input logic [31:0] exp);
    drive_cmd(mv, idx, fv, idx, fd, cv, idx, qv, idx);
    apply_model(mv, idx, fv, idx, fd, cv, idx);
    @(negedge clk);
    check_dirty("dirty_valid", dirty_valid, 1'b0);
    drive_idle();
    @(negedge clk);
    check_dirty("dirty_valid", dirty_valid, qv);
    if (qv) begin
      check_dirty("dirty", dirty, model[idx]);
      if (exp != 32'hff) check_dirty("dirty", dirty, exp[0]);
    end
  endtask

  task automatic wait_idle(output int n);
    n = 0;
    @(negedge clk);
    while (busy) begin
      check_dirty("dirty_valid", dirty_valid, 1'b0);
      check_dirty("wb_valid", wb_valid, 1'b0);
      check_dirty("flush_done", flush_done, 1'b0);
      n++;
      if (n > 2 * NUM_LINES) begin
        $display("Busy stayed high for more than %0d cycles", n);
        abort_run();
      end
      @(negedge clk);
    end
  endtask

  // A query and a flush ride on the first sweep cycle and must be dropped
  task automatic init_lines();
    int n;
    @(posedge clk);
    init <= 1'b1;
    drive_cmd(1'b0, '0, 1'b0, '0, 1'b0, 1'b0, '0, 1'b1, '0);
    flush_start <= 1'b1;
    drive_idle();
    wait_idle(n);
    check_count("sweep cycles", n + 1, NUM_WORDS);    // First sweep cycle is not counted
    for (int i = 0; i < NUM_LINES; i++) model[i] = 1'b0;
  endtask

  // Writebacks come in ascending line order and done is due 66 cycles after start
  task automatic flush_lines(input logic [31:0] exp_count, input logic inject,
                             input line_index_t inj);
    line_index_t pending [$];
    int          cyc;
    int          hits;
    for (int i = 0; i < NUM_LINES; i++) begin
      if (model[i]) pending.push_back(line_index_t'(i));
    end
    cyc  = 0;
    hits = 0;
    @(posedge clk);
    flush_start <= 1'b1;
    forever begin
      if (inject && cyc == 39) begin
        drive_cmd(1'b1, inj, 1'b1, inj, 1'b1, 1'b0, '0, 1'b1, inj);
        init <= 1'b1;                                 // Line inj was scanned long before
      end else begin
        drive_idle();
      end
      cyc++;
      @(negedge clk);
      check_dirty("busy", busy, 1'b1);
      check_dirty("dirty_valid", dirty_valid, 1'b0);
      if (wb_valid) begin
        hits++;
        if (pending.size() == 0) begin
          $display("Writeback of line 0x%h which the model holds clean", wb_index);
          abort_run();
        end
        check_index("wb_index", wb_index, pending.pop_front());
      end
      if (flush_done) break;
      if (cyc > 2 * NUM_LINES) begin
        $display("Flush did not finish within %0d cycles", cyc);
        abort_run();
      end
    end
    check_count("flush_done cycle", cyc, NUM_LINES + 2);
    check_count("missed writebacks", pending.size(), 0);
    if (exp_count != 32'hff) check_count("writeback count", hits, int'(exp_count));
    @(negedge clk);
    check_dirty("busy", busy, 1'b0);
    check_dirty("flush_done", flush_done, 1'b0);
    for (int i = 0; i < NUM_LINES; i++) model[i] = 1'b0;
  endtask

  task automatic query_all(input logic [31:0] exp_count);
    int n;
    n = 0;
    for (int i = 0; i < NUM_LINES; i++) begin
      run_op(1'b0, 1'b0, 1'b0, 1'b0, 1'b1, line_index_t'(i), 32'hff);
      if (dirty) n++;
    end
    if (exp_count != 32'hff) check_count("dirty lines", n, int'(exp_count));
  endtask

  task automatic random_burst(input int n);
    logic [31:0] r;
    line_index_t mi;
    line_index_t fi;
    line_index_t ci;
    repeat (n) begin
      r  = $urandom;
      mi = line_index_t'($urandom);
      fi = line_index_t'($urandom);
      ci = line_index_t'($urandom);
      drive_cmd(r[0], mi, r[1], fi, r[2], r[3], ci, 1'b0, '0);
      apply_model(r[0], mi, r[1], fi, r[2], r[3], ci);
    end
    drive_idle();
    @(negedge clk);
  endtask

  // Watchdog sized from the stimulus length
  initial begin
    wait (budget > 0);
    repeat (budget) @(posedge clk);
    $display("Watchdog expired after %0d cycles before the stimulus finished", budget);
    abort_run();
  end

  initial begin
    int               fd;
    int               rc;
    int               n;
    string            op;
    logic [31:0]      f_idx;
    logic [31:0]      f_val;
    logic [31:0]      f_exp;
    logic [8*160-1:0] line;
    rc = $urandom(32'h251f9991);
    rst <= 1'b1;
    set_inputs(1'b0, '0, 1'b0, '0, 1'b0, 1'b0, '0, 1'b0, '0);
    for (int i = 0; i < NUM_LINES; i++) model[i] = 1'b0;
    fd = $fopen("dv/dirty_stimulus.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the stimulus file dv/dirty_stimulus.txt");
      abort_run();
    end
    n = 0;
    while ($fgets(line, fd) > 0) n++;
    $fclose(fd);
    budget = n * 80;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    wait_idle(n);
    check_count("sweep cycles after reset", n, NUM_WORDS);
    fd = $fopen("dv/dirty_stimulus.txt", "r");
    while ($fscanf(fd, "%s", op) == 1) begin
      if (op == "#") begin
        rc = $fgets(line, fd);                        // Skip the rest of a comment line
      end else begin
        rc = $fscanf(fd, "%h %h %h", f_idx, f_val, f_exp);
        if (rc != 3) begin
          $display("Stimulus line for %s holds %0d of its 3 numbers", op, rc);
          abort_run();
        end
        case (op)
          "mark":      run_op(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, line_index_t'(f_idx), f_exp);
          "fill":      run_op(1'b0, 1'b1, f_val[0], 1'b0, 1'b0, line_index_t'(f_idx), f_exp);
          "clean":     run_op(1'b0, 1'b0, 1'b0, 1'b1, 1'b0, line_index_t'(f_idx), f_exp);
          "query":     run_op(1'b0, 1'b0, 1'b0, 1'b0, 1'b1, line_index_t'(f_idx), f_exp);
          "markfill":  run_op(1'b1, 1'b1, f_val[0], 1'b0, 1'b0, line_index_t'(f_idx), f_exp);
          "markclean": run_op(1'b1, 1'b0, 1'b0, 1'b1, 1'b0, line_index_t'(f_idx), f_exp);
          "markquery": run_op(1'b1, 1'b0, 1'b0, 1'b0, 1'b1, line_index_t'(f_idx), f_exp);
          "init":      init_lines();
          "flush":     flush_lines(f_exp, 1'b0, '0);
          "busyflush": flush_lines(f_exp, 1'b1, line_index_t'(f_idx));
          "random":    random_burst(int'(f_val));
          "queryall":  query_all(f_exp);
          "idle":      repeat (f_idx) @(posedge clk);
          default: begin
            $display("Unknown operation %s in the stimulus file", op);
            abort_run();
          end
        endcase
      end
    end
    $fclose(fd);
    $display("TEST PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== rtl/dcache_dirty_unit.sv ====
//////////////////////////////////////////////////
// Top level of the data cache dirty-line tracker
// Wires the dirty RAM, command tracker and scanner
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module dcache_dirty_unit import dcache_dirty_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        mark_valid,
  input  line_index_t mark_index,
  input  logic        fill_valid,
  input  line_index_t fill_index,
  input  logic        fill_dirty,
  input  logic        clean_valid,
  input  line_index_t clean_index,
  input  logic        query_valid,
  input  line_index_t query_index,
  input  logic        init,
  input  logic        flush_start,
  output logic        dirty_valid,
  output logic        dirty,
  output logic        wb_valid,
  output line_index_t wb_index,
  output logic        flush_done,
  output logic        busy
);

  logic        rd_en;
  word_addr_t  raddr;
  dirty_word_t rdata;
  logic        flush_go;

  dirty_write_if wr0_bus ();
  dirty_write_if wr1_bus ();
  dirty_scan_if  scan_bus ();

  assign flush_go = flush_start & ~busy;              // Flush is a command like the others

  dirty_bit_ram dirty_bit_ram_inst (
    .clk   (clk),
    .rst   (rst),
    .wr0   (wr0_bus),
    .wr1   (wr1_bus),
    .rd_en (rd_en),
    .raddr (raddr),
    .rdata (rdata)
  );

  dirty_tracker dirty_tracker_inst (
    .clk         (clk),
    .rst         (rst),
    .mark_valid  (mark_valid),
    .mark_index  (mark_index),
    .fill_valid  (fill_valid),
    .fill_index  (fill_index),
    .fill_dirty  (fill_dirty),
    .clean_valid (clean_valid),
    .clean_index (clean_index),
    .query_valid (query_valid),
    .query_index (query_index),
    .init        (init),
    .dirty_valid (dirty_valid),
    .dirty       (dirty),
    .busy        (busy),
    .wr0         (wr0_bus),
    .wr1         (wr1_bus),
    .rd_en       (rd_en),
    .raddr       (raddr),
    .rdata       (rdata),
    .scan        (scan_bus)
  );

  flush_scanner flush_scanner_inst (
    .clk         (clk),
    .rst         (rst),
    .flush_start (flush_go),
    .wb_valid    (wb_valid),
    .wb_index    (wb_index),
    .flush_done  (flush_done),
    .scan        (scan_bus)
  );

endmodule

`default_nettype wire

// ==== rtl/flush_scanner.sv ====
//////////////////////////////////////////////////
// Flush scanner that walks every line, reports the
// dirty ones for writeback and cleans them
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module flush_scanner import dcache_dirty_pkg::*; (
  input  logic          clk,
  input  logic          rst,
  input  logic          flush_start,
  output logic          wb_valid,
  output line_index_t   wb_index,
  output logic          flush_done,
  dirty_scan_if.scanner scan
);

  scan_state_t state;
  line_index_t rd_idx;
  line_index_t idx_q;                                 // Index of the read in flight
  logic        valid_q;
  logic        hit;

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= SCAN_IDLE;
      rd_idx  <= '0;
      valid_q <= 1'b0;
    end else begin
      valid_q <= scan.read;
      case (state)
        SCAN_IDLE: begin
          if (flush_start) begin
            state  <= SCAN_RUN;
            rd_idx <= '0;
          end
        end
        SCAN_RUN: begin
          rd_idx <= rd_idx + 1'b1;
          if (rd_idx == line_index_t'(NUM_LINES - 1)) state <= SCAN_DONE;
        end
        SCAN_DONE: begin
          if (!valid_q) state <= SCAN_IDLE;           // Last result has drained
        end
        default: state <= SCAN_IDLE;
      endcase
    end
  end

  // Pairs each returned bit with the index that was read
  always_ff @(posedge clk) begin
    if (scan.read) idx_q <= rd_idx;
  end

  assign scan.read       = (state == SCAN_RUN);
  assign scan.read_index = rd_idx;
  assign scan.active     = (state != SCAN_IDLE);

  assign hit = valid_q & scan.dirty_bit;

  // Writeback report and clean go out in the same cycle
  assign wb_valid         = hit;
  assign wb_index         = idx_q;
  assign scan.clear       = hit;
  assign scan.clear_index = idx_q;

  assign flush_done = (state == SCAN_DONE) & ~valid_q;

endmodule

`default_nettype wire

// ==== rtl/dirty_tracker.sv ====
//////////////////////////////////////////////////
// Dirty tracker control for command decode, write
// port arbitration, clear sweep and read bit select
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module dirty_tracker import dcache_dirty_pkg::*; (
  input  logic          clk,
  input  logic          rst,
  input  logic          mark_valid,
  input  line_index_t   mark_index,
  input  logic          fill_valid,
  input  line_index_t   fill_index,
  input  logic          fill_dirty,
  input  logic          clean_valid,
  input  line_index_t   clean_index,
  input  logic          query_valid,
  input  line_index_t   query_index,
  input  logic          init,
  output logic          dirty_valid,
  output logic          dirty,
  output logic          busy,
  dirty_write_if.source wr0,
  dirty_write_if.source wr1,
  output logic          rd_en,
  output word_addr_t    raddr,
  input  dirty_word_t   rdata,
  dirty_scan_if.tracker scan
);

  localparam int BIT_POS_BITS = $clog2(WORD_BITS);

  init_state_t               state;
  word_addr_t                sweep_cnt;
  logic [BIT_POS_BITS-1:0]   bit_sel_q;
  line_index_t               rd_index;
  logic                      sweeping;

  // Word address lives in the low index bits
  function automatic word_addr_t word_of(input line_index_t idx);
    return idx[$bits(word_addr_t)-1:0];
  endfunction

  // One-hot enable for the bit held in the high index bits
  function automatic dirty_word_t bit_mask(input line_index_t idx);
    dirty_word_t mask;
    mask = '0;
    mask[idx[$bits(line_index_t)-1:$bits(word_addr_t)]] = 1'b1;
    return mask;
  endfunction

  assign sweeping = (state == SWEEP);
  assign busy     = sweeping | scan.active;

  // Clear sweep writes one word per cycle after reset or init
  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= SWEEP;
      sweep_cnt <= '0;
    end else begin
      case (state)
        SWEEP: begin
          sweep_cnt <= sweep_cnt + 1'b1;
          if (sweep_cnt == word_addr_t'(NUM_WORDS - 1)) state <= IDLE;
        end
        default: begin
          if (init && !busy) begin
            state     <= SWEEP;
            sweep_cnt <= '0;
          end
        end
      endcase
    end
  end

  // Port 0 marks and fills, and a fill takes the port over a mark
  assign wr0.wen    = (fill_valid | mark_valid) & ~busy;
  assign wr0.addr   = fill_valid ? word_of(fill_index) : word_of(mark_index);
  assign wr0.bit_en = fill_valid ? bit_mask(fill_index) : bit_mask(mark_index);
  assign wr0.data   = fill_valid ? {WORD_BITS{fill_dirty}} : {WORD_BITS{1'b1}};

  // Port 1 only ever writes zeros for the sweep, a scanner clean or an external clean
  always_comb begin
    wr1.data = '0;
    if (sweeping) begin
      wr1.wen    = 1'b1;
      wr1.addr   = sweep_cnt;
      wr1.bit_en = '1;
    end else if (scan.active) begin
      wr1.wen    = scan.clear;
      wr1.addr   = word_of(scan.clear_index);
      wr1.bit_en = bit_mask(scan.clear_index);
    end else begin
      wr1.wen    = clean_valid;
      wr1.addr   = word_of(clean_index);
      wr1.bit_en = bit_mask(clean_index);
    end
  end

  // Scanner has the read port for the whole flush
  assign rd_index = scan.active ? scan.read_index : query_index;
  assign rd_en    = scan.active ? scan.read : (query_valid & ~busy);
  assign raddr    = word_of(rd_index);

  always_ff @(posedge clk) begin
    if (rd_en) bit_sel_q <= rd_index[$bits(line_index_t)-1:$bits(word_addr_t)];
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      dirty_valid <= 1'b0;
    end else begin
      dirty_valid <= query_valid & ~busy;             // Dropped queries get no response
    end
  end

  assign dirty         = rdata[bit_sel_q];
  assign scan.dirty_bit = rdata[bit_sel_q];

endmodule

`default_nettype wire

// ==== rtl/dirty_bit_ram.sv ====
//////////////////////////////////////////////////
// Dirty bit array of 8 words with 8 bits each
// Two bit-enabled write ports, registered read address
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module dirty_bit_ram import dcache_dirty_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  dirty_write_if.sink wr0,
  dirty_write_if.sink wr1,
  input  logic        rd_en,
  input  word_addr_t  raddr,
  output dirty_word_t rdata
);

  dirty_word_t mem [NUM_WORDS];
  word_addr_t  raddr_q;

  // Port 1 is applied after port 0 so a clean beats a mark on the same bit
  always_ff @(posedge clk) begin
    if (wr0.wen) begin
      for (int i = 0; i < WORD_BITS; i++) begin
        if (wr0.bit_en[i]) mem[wr0.addr][i] <= wr0.data[i];
      end
    end
    if (wr1.wen) begin
      for (int i = 0; i < WORD_BITS; i++) begin
        if (wr1.bit_en[i]) mem[wr1.addr][i] <= wr1.data[i];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      raddr_q <= '0;
    end else if (rd_en) begin
      raddr_q <= raddr;
    end
  end

  // Array is read behind the address register, so same-cycle writes show up
  assign rdata = mem[raddr_q];

endmodule

`default_nettype wire

// ==== rtl/dirty_write_if.sv ====
//////////////////////////////////////////////////
// Dirty RAM write port and flush scan interfaces
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

// One bit-enabled write port of the dirty RAM
interface dirty_write_if import dcache_dirty_pkg::*; ();
  word_addr_t  addr;
  logic        wen;
  dirty_word_t bit_en;                                // Only these bits are written
  dirty_word_t data;

  modport source (output addr, wen, bit_en, data);
  modport sink   (input  addr, wen, bit_en, data);
endinterface

// Link between the tracker and the flush scanner
interface dirty_scan_if import dcache_dirty_pkg::*; ();
  logic        read;
  line_index_t read_index;
  logic        clear;
  line_index_t clear_index;
  logic        active;                                // Scanner owns the read port
  logic        dirty_bit;                             // Valid the cycle after read

  modport scanner (
    output read, read_index, clear, clear_index, active,
    input  dirty_bit
  );
  modport tracker (
    input  read, read_index, clear, clear_index, active,
    output dirty_bit
  );
endinterface

`default_nettype wire

// ==== rtl/dcache_dirty_pkg.sv ====
//////////////////////////////////////////////////
// Data cache dirty tracker shared geometry
// Line, word and bit sizes plus the state encodings
//////////////////////////////////////////////////
`default_nettype none

package dcache_dirty_pkg;

  // Cache geometry with one dirty bit per line
  localparam int NUM_LINES = 64;
  localparam int NUM_WORDS = 8;                       // Words in the dirty RAM
  localparam int WORD_BITS = 8;                       // Lines packed into one word

  // Low bits pick the RAM word, high bits pick the bit inside it
  typedef logic [$clog2(NUM_LINES)-1:0] line_index_t;

  typedef logic [$clog2(NUM_WORDS)-1:0] word_addr_t;

  // Serves as write data and as per-bit write enable
  typedef logic [WORD_BITS-1:0] dirty_word_t;

  // Tracker runs a clear sweep before it accepts commands
  typedef enum logic {
    SWEEP,
    IDLE
  } init_state_t;

  // Flush scanner walk
  typedef enum logic [1:0] {
    SCAN_IDLE,
    SCAN_RUN,                                         // Issuing one read per line
    SCAN_DONE                                         // Draining the last result
  } scan_state_t;

endpackage

`default_nettype wire
